// File: rtl/accCreator_consts.svh
`ifndef ACC_CREATOR_CONSTS_SVH
`define ACC_CREATOR_CONSTS_SVH

// stream widths
`define ACC_WORD_W 64
`define ACC_DEST_W 5
`define ACC_ID_W 4

// command codes in the low byte of the first command word
`define ACC_SETUP_HW_INST_CODE 8'h10
`define ACC_FINISH_CMD_CODE 8'h03

// acknowledge codes in the low byte of a spawnIn beat
`define ACC_ACK_REJECT 8'h00
`define ACC_ACK_OK 8'h01
`define ACC_ACK_FINAL 8'h02

`define ACC_DEST_DEPS 5'h12
`define ACC_DEST_SCHED 5'h13
`define ACC_DEST_TASKWAIT 5'h14
`define ACC_DEST_CMDOUT 5'h11

// new task header and type word layout
`define ACC_NUM_ARGS_OFFSET 8
`define ACC_NUM_DEPS_OFFSET 16
`define ACC_SEQ_ID_LO 32
`define ACC_TTYPE_LO 0
`define ACC_FPGA_BIT 40
`define ACC_INSNUM_LO 48
`define ACC_INSNUM_ANY 8'hFF

`define ACC_DEP_DIR_INOUT 8'h03

`endif

// File: rtl/accCreatorPkg.sv
`include "accCreator_consts.svh"

package accCreatorPkg;

    // one beat of any stream
    typedef logic [`ACC_WORD_W-1:0] wordT;

    typedef logic [`ACC_DEST_W-1:0] destT;

    typedef logic [7:0] ackCodeT;

    // low 32 bits of the first argument of a task command
    // childCount sits in bits 7:0, taskType in bits 31:24
    typedef struct packed {
        logic [7:0] taskType;
        logic [7:0] nArgs;
        logic [7:0] nDeps;
        logic [7:0] childCount;
    } childDescT;

    // word 0 goes out first
    typedef wordT [1:0] taskwaitFrameT;

    typedef wordT [2:0] finishFrameT;

endpackage

// File: rtl/frameSender.sv
`timescale 1ns/1ps
`include "accCreator_consts.svh"

module frameSender #(
    parameter type frameT = accCreatorPkg::taskwaitFrameT,
    parameter accCreatorPkg::destT dest = `ACC_DEST_TASKWAIT
) (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 start,
    input  frameT                frame,
    output logic                 outValid,
    output accCreatorPkg::wordT  outData,
    output logic                 outLast,
    output accCreatorPkg::destT  outDest,
    input  logic                 outReady,
    output logic                 done
);

    localparam int nWords = $bits(frameT) / $bits(accCreatorPkg::wordT);
    localparam int idxW = $clog2(nWords);

    frameT frameQ;
    accCreatorPkg::wordT [nWords-1:0] words;
    logic [idxW-1:0] idx;

    assign words = frameQ;  // same width, viewed word by word
    assign outData = words[idx];
    assign outLast = idx == idxW'(nWords - 1);
    assign outDest = dest;
    assign done = outValid && outReady && outLast;

    always_ff @(posedge clk) begin
        if (rst) begin
            outValid <= 1'b0;
            idx <= '0;
        end else if (start) begin
            outValid <= 1'b1;
            idx <= '0;
        end else if (outValid && outReady) begin
            if (outLast) begin
                outValid <= 1'b0;
            end
            idx <= outLast ? '0 : idx + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (start) frameQ <= frame;
    end

endmodule

// File: rtl/spawnSender.sv
`timescale 1ns/1ps
`include "accCreator_consts.svh"

module spawnSender (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      spawnStart,
    input  accCreatorPkg::wordT       tid,
    input  accCreatorPkg::childDescT  childDesc,
    input  logic [7:0]                childSeq,
    input  logic                      zeroDeps,
    output logic                      spawnOutValid,
    output accCreatorPkg::wordT       spawnOutData,
    output logic                      spawnOutLast,
    output accCreatorPkg::destT       spawnOutDest,
    input  logic                      spawnOutReady,
    output logic                      spawnDone
);

    accCreatorPkg::wordT tidQ;
    logic [7:0] nDepsQ;
    logic [7:0] nArgsQ;
    logic [7:0] taskTypeQ;
    logic [7:0] seqQ;

    logic [9:0] pos;
    logic [9:0] total;
    logic [9:0] depIdx;
    logic [9:0] argIdx;
    logic xfer;

    assign total = 10'd3 + 10'(nDepsQ) + 10'(nArgsQ);
    assign depIdx = pos - 10'd3;
    assign argIdx = pos - 10'd3 - 10'(nDepsQ);
    assign xfer = spawnOutValid && spawnOutReady;

    assign spawnOutLast = pos == total - 10'd1;
    assign spawnOutDest = (nDepsQ != 8'd0) ? `ACC_DEST_DEPS : `ACC_DEST_SCHED;
    assign spawnDone = xfer && spawnOutLast;

    always_comb begin
        spawnOutData = '0;
        if (pos == 10'd0) begin
            spawnOutData[`ACC_NUM_ARGS_OFFSET +: 8] = nArgsQ;
            spawnOutData[`ACC_NUM_DEPS_OFFSET +: 8] = nDepsQ;
            spawnOutData[`ACC_SEQ_ID_LO +: 32] = {24'd0, seqQ};
        end else if (pos == 10'd1) begin
            spawnOutData = tidQ;  // parent of the child is this task
        end else if (pos == 10'd2) begin
            spawnOutData[`ACC_TTYPE_LO +: 8] = taskTypeQ;
            spawnOutData[`ACC_FPGA_BIT] = 1'b1;
            spawnOutData[`ACC_INSNUM_LO +: 8] = `ACC_INSNUM_ANY;
        end else if (depIdx < 10'(nDepsQ)) begin
            spawnOutData[31:0] = tidQ[31:0] + (32'(depIdx) << 3);
            spawnOutData[55:32] = tidQ[23:0];  // siblings share the parent tag
            spawnOutData[63:56] = `ACC_DEP_DIR_INOUT;
        end else if (argIdx == 10'd0) begin
            spawnOutData = {56'd0, seqQ};
        end else begin
            spawnOutData = tidQ + 64'(argIdx);
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            spawnOutValid <= 1'b0;
            pos <= '0;
        end else if (spawnStart) begin
            spawnOutValid <= 1'b1;
            pos <= '0;
        end else if (xfer) begin
            if (spawnOutLast) begin
                spawnOutValid <= 1'b0;
                pos <= '0;
            end else begin
                pos <= pos + 10'd1;
            end
        end
    end

    // child fields are frozen for the whole packet
    always_ff @(posedge clk) begin
        if (spawnStart) begin
            tidQ <= tid;
            nDepsQ <= zeroDeps ? 8'd0 : childDesc.nDeps;
            nArgsQ <= childDesc.nArgs;
            taskTypeQ <= childDesc.taskType;
            seqQ <= childSeq;
        end
    end

    stallStable: assert property (@(posedge clk) disable iff (rst)
        (spawnOutValid && !spawnOutReady) |=> (spawnOutValid && $stable(spawnOutData)));

endmodule

// File: rtl/cmdInParser.sv
`timescale 1ns/1ps
`include "accCreator_consts.svh"

module cmdInParser (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      inValid,
    input  accCreatorPkg::wordT       inData,
    input  logic                      inLast,
    output logic                      inReady,
    output logic                      cmdDone,
    output accCreatorPkg::wordT       tid,
    output accCreatorPkg::wordT       ptid,
    output accCreatorPkg::childDescT  childDesc
);

    typedef enum logic [2:0] {
        sHead,
        sSetup,
        sTid,
        sPtid,
        sArg0,
        sArgs,
        sDone
    } stateT;

    stateT state;
    logic beat;

    assign inReady = state != sDone;
    assign beat = inValid && inReady;
    assign cmdDone = state == sDone;

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= sHead;
        end else begin
            case (state)
                sHead: if (beat) begin
                    state <= (inData[7:0] == `ACC_SETUP_HW_INST_CODE) ? sSetup : sTid;
                end
                sSetup: if (beat) state <= sHead;  // second setup word is dropped
                sTid: if (beat) state <= sPtid;
                sPtid: if (beat) state <= inLast ? sDone : sArg0;
                sArg0: if (beat) state <= inLast ? sDone : sArgs;
                sArgs: if (beat && inLast) state <= sDone;
                default: state <= sHead;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (beat && state == sTid) tid <= inData;
        if (beat && state == sPtid) begin
            ptid <= inData;
            childDesc <= '0;  // no arguments means no children
        end
        if (beat && state == sArg0) childDesc <= inData[31:0];
    end

    // a beat offered while the parser holds off after Last must wait unchanged
    heldBeat: assert property (@(posedge clk) disable iff (rst)
        (inValid && !inReady) |=> (inValid && $stable(inData) && $stable(inLast)));

endmodule

// File: rtl/creatorControl.sv
`timescale 1ns/1ps
`include "accCreator_consts.svh"

module creatorControl (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          cmdDone,
    input  accCreatorPkg::wordT           tid,
    input  accCreatorPkg::wordT           ptid,
    input  accCreatorPkg::childDescT      childDesc,
    output logic                          spawnStart,
    output logic [7:0]                    childSeq,
    output logic                          zeroDeps,
    input  logic                          spawnDone,
    input  logic                          spawnInValid,
    input  accCreatorPkg::wordT           spawnInData,
    output logic                          spawnInReady,
    output logic                          twStart,
    output accCreatorPkg::taskwaitFrameT  twFrame,
    input  logic                          twDone,
    input  logic                          taskwaitInValid,
    output logic                          taskwaitInReady,
    output logic                          finStart,
    output accCreatorPkg::finishFrameT    finFrame,
    input  logic                          finDone
);

    typedef enum logic [3:0] {
        sIdle,
        sSpawnGo,
        sSpawning,
        sAck,
        sTwGo,
        sTwSending,
        sTwWait,
        sFinGo,
        sFinSending
    } stateT;

    stateT state;
    logic [7:0] acceptCnt;
    logic finalSeen;
    accCreatorPkg::ackCodeT ackCode;
    logic ackBeat;

    assign ackCode = spawnInData[7:0];
    assign ackBeat = spawnInValid && spawnInReady;

    // start pulses are one-cycle states, so they are registered
    assign spawnStart = state == sSpawnGo;
    assign twStart = state == sTwGo;
    assign finStart = state == sFinGo;
    assign spawnInReady = state == sAck;
    assign taskwaitInReady = state == sTwWait;
    assign childSeq = acceptCnt;

    assign twFrame[0] = {24'd0, 8'h01, 24'd0, acceptCnt};
    assign twFrame[1] = tid;
    assign finFrame[0] = {56'd0, `ACC_FINISH_CMD_CODE};
    assign finFrame[1] = tid;
    assign finFrame[2] = ptid;

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= sIdle;
            acceptCnt <= '0;
            finalSeen <= 1'b0;
            zeroDeps <= 1'b0;
        end else begin
            case (state)
                sIdle: if (cmdDone) begin
                    acceptCnt <= '0;
                    finalSeen <= 1'b0;
                    zeroDeps <= 1'b0;
                    state <= (childDesc.childCount == 8'd0) ? sTwGo : sSpawnGo;
                end
                sSpawnGo: state <= sSpawning;
                sSpawning: if (spawnDone) state <= sAck;
                sAck: if (ackBeat) begin
                    if (ackCode == `ACC_ACK_OK) begin
                        acceptCnt <= acceptCnt + 8'd1;
                        // final mode stops after the first accepted child
                        if (finalSeen || acceptCnt + 8'd1 == childDesc.childCount) begin
                            state <= sTwGo;
                        end else begin
                            state <= sSpawnGo;
                        end
                    end else if (ackCode == `ACC_ACK_FINAL) begin
                        finalSeen <= 1'b1;
                        zeroDeps <= 1'b1;
                        state <= sSpawnGo;
                    end else if (ackCode == `ACC_ACK_REJECT) begin
                        state <= sSpawnGo;  // same child again
                    end
                end
                sTwGo: state <= sTwSending;
                sTwSending: if (twDone) state <= sTwWait;
                sTwWait: if (taskwaitInValid) state <= sFinGo;
                sFinGo: state <= sFinSending;
                sFinSending: if (finDone) state <= sIdle;
                default: state <= sIdle;
            endcase
        end
    end

    knownAck: assert property (@(posedge clk) disable iff (rst)
        ackBeat |-> (ackCode == `ACC_ACK_OK || ackCode == `ACC_ACK_REJECT ||
                     ackCode == `ACC_ACK_FINAL));

endmodule

// File: rtl/accCreator.sv
`timescale 1ns/1ps
`include "accCreator_consts.svh"

module accCreator #(
    parameter int accId = 0
) (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   inValid,
    input  logic [`ACC_WORD_W-1:0] inData,
    input  logic                   inLast,
    output logic                   inReady,
    output logic                   spawnOutValid,
    output logic [`ACC_WORD_W-1:0] spawnOutData,
    output logic                   spawnOutLast,
    output logic [`ACC_DEST_W-1:0] spawnOutDest,
    output logic [`ACC_ID_W-1:0]   spawnOutId,
    input  logic                   spawnOutReady,
    input  logic                   spawnInValid,
    input  logic [`ACC_WORD_W-1:0] spawnInData,
    output logic                   spawnInReady,
    output logic                   taskwaitOutValid,
    output logic [`ACC_WORD_W-1:0] taskwaitOutData,
    output logic                   taskwaitOutLast,
    output logic [`ACC_DEST_W-1:0] taskwaitOutDest,
    output logic [`ACC_ID_W-1:0]   taskwaitOutId,
    input  logic                   taskwaitOutReady,
    input  logic                   taskwaitInValid,
    output logic                   taskwaitInReady,
    output logic                   cmdOutValid,
    output logic [`ACC_WORD_W-1:0] cmdOutData,
    output logic                   cmdOutLast,
    output logic [`ACC_DEST_W-1:0] cmdOutDest,
    output logic [`ACC_ID_W-1:0]   cmdOutId,
    input  logic                   cmdOutReady
);

    logic cmdDone;
    logic [`ACC_WORD_W-1:0] tid;
    logic [`ACC_WORD_W-1:0] ptid;
    logic [31:0] childDesc;
    logic spawnStart;
    logic [7:0] childSeq;
    logic zeroDeps;
    logic spawnDone;
    logic twStart;
    logic [1:0][`ACC_WORD_W-1:0] twFrame;
    logic twDone;
    logic finStart;
    logic [2:0][`ACC_WORD_W-1:0] finFrame;
    logic finDone;

    assign spawnOutId = `ACC_ID_W'(accId);
    assign taskwaitOutId = `ACC_ID_W'(accId);
    assign cmdOutId = `ACC_ID_W'(accId);

    cmdInParser parser (
        .clk(clk),
        .rst(rst),
        .inValid(inValid),
        .inData(inData),
        .inLast(inLast),
        .inReady(inReady),
        .cmdDone(cmdDone),
        .tid(tid),
        .ptid(ptid),
        .childDesc(childDesc)
    );

    creatorControl control (
        .clk(clk),
        .rst(rst),
        .cmdDone(cmdDone),
        .tid(tid),
        .ptid(ptid),
        .childDesc(childDesc),
        .spawnStart(spawnStart),
        .childSeq(childSeq),
        .zeroDeps(zeroDeps),
        .spawnDone(spawnDone),
        .spawnInValid(spawnInValid),
        .spawnInData(spawnInData),
        .spawnInReady(spawnInReady),
        .twStart(twStart),
        .twFrame(twFrame),
        .twDone(twDone),
        .taskwaitInValid(taskwaitInValid),
        .taskwaitInReady(taskwaitInReady),
        .finStart(finStart),
        .finFrame(finFrame),
        .finDone(finDone)
    );

    spawnSender spawner (
        .clk(clk),
        .rst(rst),
        .spawnStart(spawnStart),
        .tid(tid),
        .childDesc(childDesc),
        .childSeq(childSeq),
        .zeroDeps(zeroDeps),
        .spawnOutValid(spawnOutValid),
        .spawnOutData(spawnOutData),
        .spawnOutLast(spawnOutLast),
        .spawnOutDest(spawnOutDest),
        .spawnOutReady(spawnOutReady),
        .spawnDone(spawnDone)
    );

    frameSender #(
        .frameT(logic [1:0][`ACC_WORD_W-1:0]),
        .dest(`ACC_DEST_TASKWAIT)
    ) taskwaitSender (
        .clk(clk),
        .rst(rst),
        .start(twStart),
        .frame(twFrame),
        .outValid(taskwaitOutValid),
        .outData(taskwaitOutData),
        .outLast(taskwaitOutLast),
        .outDest(taskwaitOutDest),
        .outReady(taskwaitOutReady),
        .done(twDone)
    );

    frameSender #(
        .frameT(logic [2:0][`ACC_WORD_W-1:0]),
        .dest(`ACC_DEST_CMDOUT)
    ) finishSender (
        .clk(clk),
        .rst(rst),
        .start(finStart),
        .frame(finFrame),
        .outValid(cmdOutValid),
        .outData(cmdOutData),
        .outLast(cmdOutLast),
        .outDest(cmdOutDest),
        .outReady(cmdOutReady),
        .done(finDone)
    );

endmodule

// File: tb/accCreatorTb.sv
`timescale 1ns/1ps
`include "accCreator_consts.svh"

module accCreatorTb;

    localparam int numCmds = 30;
    localparam int accId = 5;
    localparam int clkPeriod = 8;

    logic clk;
    logic rst;
    logic inValid;
    accCreatorPkg::wordT inData;
    logic inLast;
    logic inReady;
    logic spawnOutValid;
    accCreatorPkg::wordT spawnOutData;
    logic spawnOutLast;
    accCreatorPkg::destT spawnOutDest;
    logic [`ACC_ID_W-1:0] spawnOutId;
    logic spawnOutReady;
    logic spawnInValid;
    accCreatorPkg::wordT spawnInData;
    logic spawnInReady;
    logic taskwaitOutValid;
    accCreatorPkg::wordT taskwaitOutData;
    logic taskwaitOutLast;
    accCreatorPkg::destT taskwaitOutDest;
    logic [`ACC_ID_W-1:0] taskwaitOutId;
    logic taskwaitOutReady;
    logic taskwaitInValid;
    logic taskwaitInReady;
    logic cmdOutValid;
    accCreatorPkg::wordT cmdOutData;
    logic cmdOutLast;
    accCreatorPkg::destT cmdOutDest;
    logic [`ACC_ID_W-1:0] cmdOutId;
    logic cmdOutReady;

    integer seed;

    // expected beats per output stream, oldest first
    accCreatorPkg::wordT spawnDataQ[$];
    bit spawnLastQ[$];
    accCreatorPkg::destT spawnDestQ[$];
    accCreatorPkg::wordT twDataQ[$];
    bit twLastQ[$];
    accCreatorPkg::wordT cmdDataQ[$];
    bit cmdLastQ[$];

    int spawnExpected;
    int twExpected;
    int cmdExpected;
    int spawnPkts;  // packets seen by the monitors
    int twPkts;
    int cmdPkts;

    accCreator #(.accId(accId)) dut (
        .clk(clk),
        .rst(rst),
        .inValid(inValid),
        .inData(inData),
        .inLast(inLast),
        .inReady(inReady),
        .spawnOutValid(spawnOutValid),
        .spawnOutData(spawnOutData),
        .spawnOutLast(spawnOutLast),
        .spawnOutDest(spawnOutDest),
        .spawnOutId(spawnOutId),
        .spawnOutReady(spawnOutReady),
        .spawnInValid(spawnInValid),
        .spawnInData(spawnInData),
        .spawnInReady(spawnInReady),
        .taskwaitOutValid(taskwaitOutValid),
        .taskwaitOutData(taskwaitOutData),
        .taskwaitOutLast(taskwaitOutLast),
        .taskwaitOutDest(taskwaitOutDest),
        .taskwaitOutId(taskwaitOutId),
        .taskwaitOutReady(taskwaitOutReady),
        .taskwaitInValid(taskwaitInValid),
        .taskwaitInReady(taskwaitInReady),
        .cmdOutValid(cmdOutValid),
        .cmdOutData(cmdOutData),
        .cmdOutLast(cmdOutLast),
        .cmdOutDest(cmdOutDest),
        .cmdOutId(cmdOutId),
        .cmdOutReady(cmdOutReady)
    );

    always #(clkPeriod / 2) clk = ~clk;

    function automatic int randBelow(input int n);
        randBelow = $unsigned($random(seed)) % n;
    endfunction

    task automatic failRun(input string why);
        $display("%s", why);
        $display("Simulation finished: FAIL");
        $fatal(1);
    endtask

    task automatic checkWord(input string name, input accCreatorPkg::wordT got,
                             input accCreatorPkg::wordT exp);
        if (got !== exp) begin
            failRun($sformatf("Fail at %0t ns: %s is %h, expected %h", $time, name, got, exp));
        end
    endtask

    task automatic checkDest(input string name, input accCreatorPkg::destT got,
                             input accCreatorPkg::destT exp);
        if (got !== exp) begin
            failRun($sformatf("Fail at %0t ns: %s is %h, expected %h", $time, name, got, exp));
        end
    endtask

    task automatic checkLast(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            failRun($sformatf("Fail at %0t ns: %s is %b, expected %b", $time, name, got, exp));
        end
    endtask

    task automatic checkId(input string name, input logic [`ACC_ID_W-1:0] got);
        if (got !== `ACC_ID_W'(accId)) begin
            failRun($sformatf("Fail at %0t ns: %s is %h, expected %h", $time, name, got,
                              `ACC_ID_W'(accId)));
        end
    endtask

    task automatic pushSpawn(input accCreatorPkg::wordT w, input accCreatorPkg::destT d);
        spawnDataQ.push_back(w);
        spawnLastQ.push_back(1'b0);
        spawnDestQ.push_back(d);
    endtask

    task automatic expectSpawn(input accCreatorPkg::wordT tid, input logic [7:0] seq,
                               input logic [7:0] nDeps, input logic [7:0] nArgs,
                               input logic [7:0] taskType);
        accCreatorPkg::wordT w;
        accCreatorPkg::destT d;
        d = (nDeps != 8'd0) ? `ACC_DEST_DEPS : `ACC_DEST_SCHED;
        w = '0;
        w[`ACC_NUM_ARGS_OFFSET +: 8] = nArgs;
        w[`ACC_NUM_DEPS_OFFSET +: 8] = nDeps;
        w[`ACC_SEQ_ID_LO +: 8] = seq;
        pushSpawn(w, d);
        pushSpawn(tid, d);
        w = '0;
        w[`ACC_TTYPE_LO +: 8] = taskType;
        w[`ACC_FPGA_BIT] = 1'b1;
        w[`ACC_INSNUM_LO +: 8] = `ACC_INSNUM_ANY;
        pushSpawn(w, d);
        for (int i = 0; i < int'(nDeps); i++) begin
            pushSpawn({`ACC_DEP_DIR_INOUT, tid[23:0], tid[31:0] + 32'(8 * i)}, d);
        end
        for (int i = 0; i < int'(nArgs); i++) begin
            pushSpawn((i == 0) ? {56'd0, seq} : tid + 64'(i), d);
        end
        spawnLastQ[spawnLastQ.size() - 1] = 1'b1;
        spawnExpected++;
    endtask

    task automatic expectTaskwait(input logic [7:0] accepted, input accCreatorPkg::wordT tid);
        twDataQ.push_back({24'd0, 8'h01, 24'd0, accepted});
        twLastQ.push_back(1'b0);
        twDataQ.push_back(tid);
        twLastQ.push_back(1'b1);
        twExpected++;
    endtask

    task automatic expectFinish(input accCreatorPkg::wordT tid, input accCreatorPkg::wordT ptid);
        cmdDataQ.push_back({56'd0, `ACC_FINISH_CMD_CODE});
        cmdLastQ.push_back(1'b0);
        cmdDataQ.push_back(tid);
        cmdLastQ.push_back(1'b0);
        cmdDataQ.push_back(ptid);
        cmdLastQ.push_back(1'b1);
        cmdExpected++;
    endtask

    task automatic idleCycles(input int n);
        repeat (n) begin
            @(posedge clk);
            #1;
        end
    endtask

    // entered 1 ns after an edge, returns 1 ns after the accepting edge
    task automatic sendBeat(input accCreatorPkg::wordT data, input logic last);
        idleCycles(randBelow(3));
        inValid = 1'b1;
        inData = data;
        inLast = last;
        @(posedge clk);
        while (!inReady) @(posedge clk);
        #1;
        inValid = 1'b0;
    endtask

    task automatic sendSetup();
        sendBeat({$random(seed), 24'd0, `ACC_SETUP_HW_INST_CODE}, 1'b0);
        sendBeat({$random(seed), $random(seed)}, 1'b1);
    endtask

    task automatic driveAck(input accCreatorPkg::ackCodeT code);
        spawnInValid = 1'b1;
        spawnInData = {$random(seed), 24'd0, code};
        @(posedge clk);
        while (!spawnInReady) @(posedge clk);
        #1;
        spawnInValid = 1'b0;
    endtask

    task automatic runTask();
        accCreatorPkg::wordT tid;
        accCreatorPkg::wordT ptid;
        accCreatorPkg::ackCodeT code;
        int argWords;
        int r;
        logic [7:0] cc;
        logic [7:0] nd;
        logic [7:0] na;
        logic [7:0] ttype;
        logic [7:0] accepted;
        bit finalSeen;
        bit spawning;
        tid = {$random(seed), $random(seed)};
        ptid = {$random(seed), $random(seed)};
        argWords = (randBelow(8) == 0) ? 0 : 1 + randBelow(2);
        cc = 8'(randBelow(5));
        nd = 8'(randBelow(4));
        na = 8'(randBelow(4));
        ttype = 8'(randBelow(256));
        if (argWords == 0) begin
            cc = 8'd0;  // a task without arguments has no child descriptor
        end
        accepted = 8'd0;
        finalSeen = 1'b0;
        spawning = cc != 8'd0;
        sendBeat({$random(seed), 24'd0, 8'h01}, 1'b0);
        sendBeat(tid, 1'b0);
        sendBeat(ptid, argWords == 0);
        if (argWords > 0) sendBeat({$random(seed), ttype, na, nd, cc}, argWords == 1);
        if (argWords > 1) sendBeat({$random(seed), $random(seed)}, 1'b1);
        if (spawning) expectSpawn(tid, 8'd0, nd, na, ttype);
        else expectTaskwait(8'd0, tid);
        while (spawning) begin
            @(posedge clk);
            while (spawnPkts != spawnExpected) @(posedge clk);
            #1;
            r = randBelow(10);
            code = (r < 6) ? `ACC_ACK_OK : ((r < 8) ? `ACC_ACK_REJECT : `ACC_ACK_FINAL);
            if (code == `ACC_ACK_OK) begin
                accepted = accepted + 8'd1;
                if (finalSeen || accepted == cc) spawning = 1'b0;
            end else if (code == `ACC_ACK_FINAL) begin
                finalSeen = 1'b1;
            end
            driveAck(code);
            if (spawning) expectSpawn(tid, accepted, finalSeen ? 8'd0 : nd, na, ttype);
            else expectTaskwait(accepted, tid);
        end
        @(posedge clk);
        while (twPkts != twExpected) @(posedge clk);
        #1;
        idleCycles(randBelow(6));
        taskwaitInValid = 1'b1;
        @(posedge clk);
        while (!taskwaitInReady) @(posedge clk);
        #1;
        taskwaitInValid = 1'b0;
        expectFinish(tid, ptid);  // only legal once the completion went in
        @(posedge clk);
        while (cmdPkts != cmdExpected) @(posedge clk);
        #1;
    endtask

    always @(posedge clk) begin
        #1;
        spawnOutReady = randBelow(10) < 7;
        taskwaitOutReady = randBelow(10) < 7;
        cmdOutReady = randBelow(10) < 7;
    end

    always @(posedge clk) begin
        if (!rst && spawnOutValid && spawnOutReady) begin
            if (spawnDataQ.size() == 0) begin
                failRun("spawnOut sent a beat that no command asked for");
            end else begin
                checkWord("spawnOutData", spawnOutData, spawnDataQ.pop_front());
                checkLast("spawnOutLast", spawnOutLast, spawnLastQ.pop_front());
                checkDest("spawnOutDest", spawnOutDest, spawnDestQ.pop_front());
                checkId("spawnOutId", spawnOutId);
                if (spawnOutLast) spawnPkts <= spawnPkts + 1;
            end
        end
    end

    always @(posedge clk) begin
        if (!rst && taskwaitOutValid && taskwaitOutReady) begin
            if (twDataQ.size() == 0) begin
                failRun("taskwaitOut sent a beat that no command asked for");
            end else begin
                checkWord("taskwaitOutData", taskwaitOutData, twDataQ.pop_front());
                checkLast("taskwaitOutLast", taskwaitOutLast, twLastQ.pop_front());
                checkDest("taskwaitOutDest", taskwaitOutDest, `ACC_DEST_TASKWAIT);
                checkId("taskwaitOutId", taskwaitOutId);
                if (taskwaitOutLast) twPkts <= twPkts + 1;
            end
        end
    end

    always @(posedge clk) begin
        if (!rst && cmdOutValid && cmdOutReady) begin
            if (cmdDataQ.size() == 0) begin
                failRun("cmdOut sent a beat before the taskwait completion");
            end else begin
                checkWord("cmdOutData", cmdOutData, cmdDataQ.pop_front());
                checkLast("cmdOutLast", cmdOutLast, cmdLastQ.pop_front());
                checkDest("cmdOutDest", cmdOutDest, `ACC_DEST_CMDOUT);
                checkId("cmdOutId", cmdOutId);
                if (cmdOutLast) cmdPkts <= cmdPkts + 1;
            end
        end
    end

    initial begin
        #(numCmds * 2000 * clkPeriod);
        failRun("timeout: the DUT stopped making progress");
    end

    initial begin
        seed = 32'h2ead;
        clk = 1'b0;
        rst = 1'b1;
        inValid = 1'b0;
        inData = '0;
        inLast = 1'b0;
        spawnOutReady = 1'b0;
        spawnInValid = 1'b0;
        spawnInData = '0;
        taskwaitOutReady = 1'b0;
        taskwaitInValid = 1'b0;
        cmdOutReady = 1'b0;
        spawnExpected = 0;
        twExpected = 0;
        cmdExpected = 0;
        spawnPkts = 0;
        twPkts = 0;
        cmdPkts = 0;
        repeat (8) @(posedge clk);
        #1;
        rst = 1'b0;
        checkLast("inReady", inReady, 1'b1);
        checkLast("spawnOutValid", spawnOutValid, 1'b0);
        checkLast("taskwaitOutValid", taskwaitOutValid, 1'b0);
        checkLast("cmdOutValid", cmdOutValid, 1'b0);
        checkLast("spawnInReady", spawnInReady, 1'b0);
        checkLast("taskwaitInReady", taskwaitInReady, 1'b0);
        for (int c = 0; c < numCmds; c++) begin
            if (randBelow(5) == 0) sendSetup();
            else runTask();
        end
        idleCycles(20);  // stray beats after a trailing setup still hit an empty queue
        if (spawnDataQ.size() == 0 && twDataQ.size() == 0 && cmdDataQ.size() == 0) begin
            $display("Simulation finished: PASS");
            $finish;
        end else begin
            failRun("expected output beats were never sent by the DUT");
        end
    end

endmodule

// File: files.f
+incdir+rtl
rtl/accCreatorPkg.sv
rtl/frameSender.sv
rtl/spawnSender.sv
rtl/cmdInParser.sv
rtl/creatorControl.sv
rtl/accCreator.sv
tb/accCreatorTb.sv

// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal -j 0 \
    -f files.f --top-module accCreatorTb -o simv

out=$(./obj_dir/simv 2>&1) || true
echo "$out"

echo "$out" | grep -qx "Simulation finished: PASS"
